// File: design/aluDecoder.sv
// ALU decoder
// maps the operation class and funct fields to the ALU control code
`timescale 1ns/1ps
`default_nettype none

module aluDecoder
    import controlPkg::*;
(
    input  wire aluOp_e     i_aluOp,
    input  wire opcode_t    i_op,
    input  wire funct3_t    i_funct3,
    input  wire logic       i_funct7b5,
    output aluCtrl_t        o_aluControl
);

    // sub only for R-type with funct7 bit 5 set, addi never subtracts
    logic isRSub;

    assign isRSub = i_op[5] & i_funct7b5;

    always_comb
    begin
        case (i_aluOp)
            aluAdd:
            begin
                o_aluControl = aluCtrlAdd;
            end
            aluSub:
            begin
                o_aluControl = aluCtrlSub;
            end
            aluFunct:
            begin
                // funct3 picks the operation
                case (i_funct3)
                    3'b000:  o_aluControl = isRSub ? aluCtrlSub : aluCtrlAdd;
                    3'b010:  o_aluControl = aluCtrlSlt;
                    3'b100:  o_aluControl = aluCtrlXor;
                    3'b110:  o_aluControl = aluCtrlOr;
                    3'b111:  o_aluControl = aluCtrlAnd;
                    default: o_aluControl = aluCtrlAdd;
                endcase
            end
            default:
            begin
                o_aluControl = aluCtrlAdd;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/controlFsm.sv
// multicycle control state machine
// steps each instruction through fetch, decode and execute states
// and decodes the datapath selects and enables from the current state
`timescale 1ns/1ps
`default_nettype none

module controlFsm
    import controlPkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire opcode_t    i_op,
    input  wire logic       i_zero,
    output logic            o_pcWrite,
    output logic            o_adrSrc,
    output logic            o_memWrite,
    output logic            o_irWrite,
    output logic            o_regWrite,
    output logic            o_illegal,
    output srcSel_t         o_resultSrc,
    output srcSel_t         o_aluSrcA,
    output srcSel_t         o_aluSrcB,
    output aluOp_e          o_aluOp
);

    ctrlState_e stateReg;
    ctrlState_e stateNext;

    // state register, reset loads fetch directly
    always_ff @(posedge clk)
    begin
        if (resetn)
        begin
            stateReg <= sFetch;
        end
        else
        begin
            stateReg <= stateNext;
        end
    end

    // next-state logic
    always_comb
    begin
        // stay put unless a rule below moves us
        stateNext = stateReg;
        case (stateReg)
            sFetch:
            begin
                stateNext = sDecode;
            end
            sDecode:
            begin
                // branch on the opcode held in the instruction register
                case (i_op)
                    opLoad, opStore:
                    begin
                        stateNext = sMemAddr;
                    end
                    opRType:
                    begin
                        stateNext = sExecR;
                    end
                    opIType:
                    begin
                        stateNext = sExecI;
                    end
                    opJal:
                    begin
                        stateNext = sJal;
                    end
                    opBranch:
                    begin
                        stateNext = sBeq;
                    end
                    opLui:
                    begin
                        stateNext = sLui;
                    end
                    opNop:
                    begin
                        stateNext = sFetch;
                    end
                    default:
                    begin
                        stateNext = sIllegal;
                    end
                endcase
            end
            sMemAddr:
            begin
                // only load and store reach here
                stateNext = (i_op == opStore) ? sMemWrite : sMemRead;
            end
            sMemRead:
            begin
                stateNext = sMemWb;
            end
            sExecR, sExecI, sJal, sLui:
            begin
                stateNext = sAluWb;
            end
            sMemWb, sMemWrite, sAluWb, sBeq:
            begin
                stateNext = sFetch;
            end
            sIllegal:
            begin
                // sticky until reset
                stateNext = sIllegal;
            end
            default:
            begin
                stateNext = sIllegal;
            end
        endcase
    end

    // Moore output decode
    always_comb
    begin
        o_pcWrite   = 1'b0;
        o_adrSrc    = 1'b0;
        o_memWrite  = 1'b0;
        o_irWrite   = 1'b0;
        o_regWrite  = 1'b0;
        o_illegal   = 1'b0;
        o_resultSrc = resAluOut;
        o_aluSrcA   = srcAPc;
        o_aluSrcB   = srcBReg;
        o_aluOp     = aluAdd;
        case (stateReg)
            sFetch:
            begin
                // latch instruction, pc + 4 straight onto the result bus
                o_irWrite   = 1'b1;
                o_pcWrite   = 1'b1;
                o_aluSrcA   = srcAPc;
                o_aluSrcB   = srcBFour;
                o_resultSrc = resAluDirect;
            end
            sDecode:
            begin
                // branch and jump target from old pc
                o_aluSrcA = srcAOldPc;
                o_aluSrcB = srcBImm;
            end
            sMemAddr:
            begin
                // rs1 + offset
                o_aluSrcA = srcAReg;
                o_aluSrcB = srcBImm;
            end
            sMemRead:
            begin
                o_adrSrc    = 1'b1;
                o_resultSrc = resAluOut;
            end
            sMemWb:
            begin
                o_resultSrc = resData;
                o_regWrite  = 1'b1;
            end
            sMemWrite:
            begin
                o_adrSrc   = 1'b1;
                o_memWrite = 1'b1;
            end
            sExecR:
            begin
                o_aluSrcA = srcAReg;
                o_aluSrcB = srcBReg;
                o_aluOp   = aluFunct;
            end
            sExecI:
            begin
                o_aluSrcA = srcAReg;
                o_aluSrcB = srcBImm;
                o_aluOp   = aluFunct;
            end
            sAluWb:
            begin
                // ALUOut register onto rd
                o_regWrite = 1'b1;
            end
            sJal:
            begin
                // jump target from decode goes to pc, link value is old pc + 4
                o_pcWrite = 1'b1;
                o_aluSrcA = srcAOldPc;
                o_aluSrcB = srcBFour;
            end
            sBeq:
            begin
                // compare by subtraction, take branch on zero
                o_aluSrcA = srcAReg;
                o_aluSrcB = srcBReg;
                o_aluOp   = aluSub;
                o_pcWrite = i_zero;
            end
            sLui:
            begin
                // zero + upper immediate
                o_aluSrcA = srcAZero;
                o_aluSrcB = srcBImm;
            end
            sIllegal:
            begin
                o_illegal = 1'b1;
            end
            default:
            begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/controlPkg.sv
// shared definitions for the multicycle RV32 control unit
// field types, opcodes, mux select codes and state encodings
`default_nettype none

package controlPkg;

    // instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // ALU control code and immediate format select
    typedef logic [2:0] aluCtrl_t;
    typedef logic [2:0] immSrc_t;

    // datapath mux select, shared by srcA, srcB and result muxes
    typedef logic [1:0] srcSel_t;

    // ALU operation class handed from the FSM to the ALU decoder
    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluFunct
    } aluOp_e;

    // one state per step of an instruction
    typedef enum logic [3:0] {
        sFetch,
        sDecode,
        sMemAddr,
        sMemRead,
        sMemWb,
        sMemWrite,
        sExecR,
        sAluWb,
        sExecI,
        sJal,
        sBeq,
        sLui,
        sIllegal
    } ctrlState_e;

    // supported opcodes
    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;
    localparam opcode_t opRType  = 7'b0110011;
    localparam opcode_t opIType  = 7'b0010011;
    localparam opcode_t opJal    = 7'b1101111;
    localparam opcode_t opBranch = 7'b1100011;
    localparam opcode_t opLui    = 7'b0110111;
    localparam opcode_t opNop    = 7'b0000000;

    // ALU operand A mux
    localparam srcSel_t srcAPc    = 2'b00;
    localparam srcSel_t srcAOldPc = 2'b01;
    localparam srcSel_t srcAReg   = 2'b10;
    localparam srcSel_t srcAZero  = 2'b11;

    // ALU operand B mux
    localparam srcSel_t srcBReg  = 2'b00;
    localparam srcSel_t srcBImm  = 2'b01;
    localparam srcSel_t srcBFour = 2'b10;

    // result bus mux
    localparam srcSel_t resAluOut    = 2'b00;
    localparam srcSel_t resData      = 2'b01;
    localparam srcSel_t resAluDirect = 2'b10;

    // ALU control codes
    localparam aluCtrl_t aluCtrlAdd = 3'b000;
    localparam aluCtrl_t aluCtrlSub = 3'b001;
    localparam aluCtrl_t aluCtrlAnd = 3'b010;
    localparam aluCtrl_t aluCtrlOr  = 3'b011;
    localparam aluCtrl_t aluCtrlXor = 3'b100;
    localparam aluCtrl_t aluCtrlSlt = 3'b101;

    // immediate formats
    localparam immSrc_t immI = 3'b000;
    localparam immSrc_t immS = 3'b001;
    localparam immSrc_t immB = 3'b010;
    localparam immSrc_t immJ = 3'b011;
    localparam immSrc_t immU = 3'b100;

endpackage

`default_nettype wire

// File: design/immDecoder.sv
// immediate format decoder
// selects the immediate extension format from the opcode
`timescale 1ns/1ps
`default_nettype none

module immDecoder
    import controlPkg::*;
(
    input  wire opcode_t    i_op,
    output immSrc_t         o_immSrc
);

    always_comb
    begin
        case (i_op)
            opStore:  o_immSrc = immS;
            opBranch: o_immSrc = immB;
            opJal:    o_immSrc = immJ;
            opLui:    o_immSrc = immU;
            // loads, I-type and everything else
            default:  o_immSrc = immI;
        endcase
    end

endmodule

`default_nettype wire

// File: design/multicycleControl.sv
// multicycle RV32 control unit top level
// connects the control FSM with the ALU and immediate decoders
`timescale 1ns/1ps
`default_nettype none

module multicycleControl
    import controlPkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetn,
    // fields from the instruction register
    input  wire opcode_t    i_op,
    input  wire funct3_t    i_funct3,
    input  wire logic       i_funct7b5,
    // ALU zero flag
    input  wire logic       i_zero,
    // datapath enables
    output logic            o_pcWrite,
    output logic            o_adrSrc,
    output logic            o_memWrite,
    output logic            o_irWrite,
    output logic            o_regWrite,
    output logic            o_illegal,
    // datapath selects
    output srcSel_t         o_resultSrc,
    output srcSel_t         o_aluSrcA,
    output srcSel_t         o_aluSrcB,
    output aluCtrl_t        o_aluControl,
    output immSrc_t         o_immSrc
);

    // operation class from FSM to ALU decoder
    aluOp_e aluOp;

    controlFsm i_controlFsm (
        .clk         (clk),
        .resetn      (resetn),
        .i_op        (i_op),
        .i_zero      (i_zero),
        .o_pcWrite   (o_pcWrite),
        .o_adrSrc    (o_adrSrc),
        .o_memWrite  (o_memWrite),
        .o_irWrite   (o_irWrite),
        .o_regWrite  (o_regWrite),
        .o_illegal   (o_illegal),
        .o_resultSrc (o_resultSrc),
        .o_aluSrcA   (o_aluSrcA),
        .o_aluSrcB   (o_aluSrcB),
        .o_aluOp     (aluOp)
    );

    // decoders look only at instruction fields
    aluDecoder i_aluDecoder (
        .i_aluOp      (aluOp),
        .i_op         (i_op),
        .i_funct3     (i_funct3),
        .i_funct7b5   (i_funct7b5),
        .o_aluControl (o_aluControl)
    );

    immDecoder i_immDecoder (
        .i_op     (i_op),
        .o_immSrc (o_immSrc)
    );

endmodule

`default_nettype wire

// File: filelist.f
design/controlPkg.sv
design/controlFsm.sv
design/aluDecoder.sv
design/immDecoder.sv
design/multicycleControl.sv
testbench/multicycleControl_chk.sv
testbench/multicycleControl_tb.sv

// File: testbench/multicycleControl_chk.sv
// concurrent checks on the control unit write enables
// bound into the top level of the control unit
`timescale 1ns/1ps
`default_nettype none

module multicycleControl_chk
(
    input  wire logic clk,
    input  wire logic resetn,
    input  wire logic i_pcWrite,
    input  wire logic i_memWrite,
    input  wire logic i_irWrite,
    input  wire logic i_regWrite,
    input  wire logic i_illegal
);

    // memory and register file never written in the same cycle
    assert property (@(posedge clk) disable iff (resetn) !(i_memWrite && i_regWrite))
        else $error("memWrite and regWrite high together");

    // fetch always advances the pc
    assert property (@(posedge clk) disable iff (resetn) i_irWrite |-> i_pcWrite)
        else $error("irWrite without pcWrite");

    // illegal state writes nothing
    assert property (@(posedge clk) disable iff (resetn)
        i_illegal |-> !(i_memWrite || i_regWrite || i_pcWrite || i_irWrite))
        else $error("write enable high in illegal state");

endmodule

bind multicycleControl multicycleControl_chk i_multicycleControl_chk (
    .clk        (clk),
    .resetn     (resetn),
    .i_pcWrite  (o_pcWrite),
    .i_memWrite (o_memWrite),
    .i_irWrite  (o_irWrite),
    .i_regWrite (o_regWrite),
    .i_illegal  (o_illegal)
);

`default_nettype wire

// File: testbench/multicycleControl_tb.sv
// random-instruction testbench for the multicycle control unit
// a cycle model predicts every output, one instruction at a time
`timescale 1ns/1ps
`default_nettype none

module multicycleControl_tb
    import controlPkg::*;
();

    localparam int numInstr  = 300;
    localparam int waitLimit = 10;

    logic       clk;
    logic       resetn;
    opcode_t    op;
    funct3_t    funct3;
    logic       funct7b5;
    logic       zero;
    logic       pcWrite;
    logic       adrSrc;
    logic       memWrite;
    logic       irWrite;
    logic       regWrite;
    logic       illegal;
    srcSel_t    resultSrc;
    srcSel_t    aluSrcA;
    srcSel_t    aluSrcB;
    aluCtrl_t   aluControl;
    immSrc_t    immSrc;

    logic [15:0] lfsr;
    ctrlState_e  modelState;

    multicycleControl i_multicycleControl (
        .clk          (clk),
        .resetn       (resetn),
        .i_op         (op),
        .i_funct3     (funct3),
        .i_funct7b5   (funct7b5),
        .i_zero       (zero),
        .o_pcWrite    (pcWrite),
        .o_adrSrc     (adrSrc),
        .o_memWrite   (memWrite),
        .o_irWrite    (irWrite),
        .o_regWrite   (regWrite),
        .o_illegal    (illegal),
        .o_resultSrc  (resultSrc),
        .o_aluSrcA    (aluSrcA),
        .o_aluSrcB    (aluSrcB),
        .o_aluControl (aluControl),
        .o_immSrc     (immSrc)
    );

    // 4 ns clock
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [15:0] takeBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsrStep(lfsr);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic opcode_t legalOp(input logic [2:0] idx);
        case (idx)
            3'd0:    return opLoad;
            3'd1:    return opStore;
            3'd2:    return opRType;
            3'd3:    return opIType;
            3'd4:    return opJal;
            3'd5:    return opBranch;
            3'd6:    return opLui;
            default: return opNop;
        endcase
    endfunction

    function automatic logic isLegal(input opcode_t o);
        return o inside {opLoad, opStore, opRType, opIType, opJal, opBranch, opLui, opNop};
    endfunction

    // cycles from one fetch to the next
    function automatic int instrCycles(input opcode_t o);
        case (o)
            opLoad:   return 5;
            opBranch: return 3;
            opNop:    return 2;
            default:  return 4;
        endcase
    endfunction

    function automatic immSrc_t expImm(input opcode_t o);
        case (o)
            opStore:  return immS;
            opBranch: return immB;
            opJal:    return immJ;
            opLui:    return immU;
            default:  return immI;
        endcase
    endfunction

    function automatic aluCtrl_t expAluCtrl(input ctrlState_e s, input opcode_t o,
                                           input funct3_t f3, input logic f7b5);
        if (s == sBeq)
            return aluCtrlSub;
        if (s != sExecR && s != sExecI)
            return aluCtrlAdd;
        case (f3)
            // subtract only for R-type with funct7 bit 5
            3'b000:  return (o == opRType && f7b5) ? aluCtrlSub : aluCtrlAdd;
            3'b010:  return aluCtrlSlt;
            3'b100:  return aluCtrlXor;
            3'b110:  return aluCtrlOr;
            3'b111:  return aluCtrlAnd;
            default: return aluCtrlAdd;
        endcase
    endfunction

    function automatic ctrlState_e nextState(input ctrlState_e s, input opcode_t o);
        case (s)
            sFetch:
            begin
                return sDecode;
            end
            sDecode:
            begin
                case (o)
                    opLoad, opStore: return sMemAddr;
                    opRType:         return sExecR;
                    opIType:         return sExecI;
                    opJal:           return sJal;
                    opBranch:        return sBeq;
                    opLui:           return sLui;
                    opNop:           return sFetch;
                    default:         return sIllegal;
                endcase
            end
            sMemAddr:
            begin
                return (o == opLoad) ? sMemRead : sMemWrite;
            end
            sMemRead:
            begin
                return sMemWb;
            end
            sExecR, sExecI, sJal, sLui:
            begin
                return sAluWb;
            end
            sIllegal:
            begin
                return sIllegal;
            end
            default:
            begin
                return sFetch;
            end
        endcase
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp)
            failRun($sformatf("error %s expected %b actual %b", name, exp, act));
    endtask

    task automatic checkSel(input string name, input srcSel_t exp, input srcSel_t act);
        if (act !== exp)
            failRun($sformatf("error %s expected %b actual %b", name, exp, act));
    endtask

    task automatic checkAluCtrl(input string name, input aluCtrl_t exp, input aluCtrl_t act);
        if (act !== exp)
            failRun($sformatf("error %s expected %b actual %b", name, exp, act));
    endtask

    task automatic checkImmSrc(input string name, input immSrc_t exp, input immSrc_t act);
        if (act !== exp)
            failRun($sformatf("error %s expected %b actual %b", name, exp, act));
    endtask

    task automatic checkLength(input string name, input int exp, input int act);
        if (act != exp)
            failRun($sformatf("error %s cycles expected %0d actual %0d", name, exp, act));
    endtask

    // compare all outputs against the model state, at the falling edge
    task automatic checkOutputs(input string tag);
        logic    expPc;
        logic    expAdr;
        logic    expMem;
        logic    expIr;
        logic    expReg;
        logic    expIll;
        srcSel_t expRes;
        srcSel_t expA;
        srcSel_t expB;
        string   t;
        t = $sformatf("%s %s", tag, modelState.name());
        expPc = 1'b0;
        expAdr = 1'b0;
        expMem = 1'b0;
        expIr = 1'b0;
        expReg = 1'b0;
        expIll = 1'b0;
        expRes = resAluOut;
        expA = srcAPc;
        expB = srcBReg;
        case (modelState)
            sFetch:
            begin
                expIr = 1'b1;
                expPc = 1'b1;
                expB = srcBFour;
                expRes = resAluDirect;
            end
            sDecode:
            begin
                expA = srcAOldPc;
                expB = srcBImm;
            end
            sMemAddr, sExecI:
            begin
                expA = srcAReg;
                expB = srcBImm;
            end
            sMemRead:   expAdr = 1'b1;
            sMemWb:
            begin
                expRes = resData;
                expReg = 1'b1;
            end
            sMemWrite:
            begin
                expAdr = 1'b1;
                expMem = 1'b1;
            end
            sExecR:     expA = srcAReg;
            sAluWb:     expReg = 1'b1;
            sJal:
            begin
                expPc = 1'b1;
                expA = srcAOldPc;
                expB = srcBFour;
            end
            sBeq:
            begin
                // branch taken on ALU zero
                expA = srcAReg;
                expPc = zero;
            end
            sLui:
            begin
                expA = srcAZero;
                expB = srcBImm;
            end
            default:    expIll = 1'b1;
        endcase
        checkBit({t, " pcWrite"}, expPc, pcWrite);
        checkBit({t, " adrSrc"}, expAdr, adrSrc);
        checkBit({t, " memWrite"}, expMem, memWrite);
        checkBit({t, " irWrite"}, expIr, irWrite);
        checkBit({t, " regWrite"}, expReg, regWrite);
        checkBit({t, " illegal"}, expIll, illegal);
        checkSel({t, " resultSrc"}, expRes, resultSrc);
        checkSel({t, " aluSrcA"}, expA, aluSrcA);
        checkSel({t, " aluSrcB"}, expB, aluSrcB);
        checkAluCtrl({t, " aluControl"}, expAluCtrl(modelState, op, funct3, funct7b5),
                     aluControl);
        checkImmSrc({t, " immSrc"}, expImm(op), immSrc);
    endtask

    // step one clock, new fields only on the edge ending a fetch
    task automatic advance(input opcode_t newOp);
        ctrlState_e  nxt;
        logic [15:0] bits;
        @(posedge clk);
        nxt = nextState(modelState, op);
        if (modelState == sFetch)
        begin
            bits = takeBits(4);
            op <= newOp;
            funct3 <= bits[2:0];
            funct7b5 <= bits[3];
        end
        bits = takeBits(1);
        zero <= bits[0];
        modelState = nxt;
    endtask

    // four reset edges, ends at the falling edge of the first fetch
    task automatic applyReset();
        resetn <= 1'b1;
        for (int k = 0; k < 4; k++)
        begin
            @(posedge clk);
            if (k == 3)
                resetn <= 1'b0;
            @(negedge clk);
            checkBit("reset memWrite", 1'b0, memWrite);
            checkBit("reset regWrite", 1'b0, regWrite);
            checkBit("reset illegal", 1'b0, illegal);
        end
        modelState = sFetch;
    endtask

    // entered and left at the falling edge of a fetch cycle
    task automatic runInstr(input int idx, input opcode_t newOp);
        int    cycles;
        string tag;
        tag = $sformatf("instr %0d op %b", idx, newOp);
        checkOutputs(tag);
        advance(newOp);
        cycles = 1;
        @(negedge clk);
        while (irWrite !== 1'b1)
        begin
            if (cycles >= waitLimit)
                failRun($sformatf("timeout: instruction %0d never returned to fetch", idx));
            checkOutputs(tag);
            advance(op);
            cycles++;
            @(negedge clk);
        end
        checkLength(tag, instrCycles(newOp), cycles);
    endtask

    initial
    begin
        logic [15:0] bits;
        opcode_t     badOp;
        resetn = 1'b1;
        op = opNop;
        funct3 = '0;
        funct7b5 = 1'b0;
        zero = 1'b0;
        lfsr = 16'd53473;
        modelState = sFetch;
        applyReset();
        for (int n = 0; n < numInstr; n++)
        begin
            bits = takeBits(3);
            runInstr(n, legalOp(bits[2:0]));
        end
        // last pick is an illegal opcode
        bits = takeBits(7);
        badOp = bits[6:0];
        if (isLegal(badOp))
            badOp = 7'b1110011;
        checkOutputs("illegal fetch");
        advance(badOp);
        // decode then the sticky illegal state
        for (int c = 0; c < 8; c++)
        begin
            @(negedge clk);
            checkOutputs($sformatf("illegal op %b cycle %0d", badOp, c));
            advance(op);
        end
        // only reset leaves the illegal state
        applyReset();
        checkOutputs("after reset");
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
